//--- Makefile
# Verilator build and run for the ray core pixel pipeline

VERILATOR     ?= verilator
TOP           ?= ray_core_tb
FILELIST      ?= files.f
BUILD_DIR     ?= obj_dir
LOG           ?= sim.log
RASTER_CYCLES ?= 16
JOBS          ?= 4
TIMESCALE     ?= 1ns/100ps

VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GRASTER_CYCLES=$(RASTER_CYCLES) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
hw/ray_core_pkg.sv
hw/stage_slot.sv
hw/ray_color_convert.sv
hw/ray_stage_ctrl.sv
hw/ray_core_top.sv
sim/ray_core_tb.sv

//--- hw/ray_color_convert.sv
// Raster color datapath
`timescale 1ns/100ps
`default_nettype none

module ray_color_convert (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    input  logic                       finish,
    input  ray_core_pkg::ray_pixel_t   ray_in,
    output ray_core_pkg::color_pixel_t pixel_out
);
    import ray_core_pkg::*;

    ray_pixel_t cur_ray;

    // ray under traversal
    always_ff @(posedge clk) begin
        if (start) begin
            cur_ray <= ray_in;
        end
    end

    // drop the fraction bits of each direction component
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pixel_out <= '0;
        end else if (finish) begin
            pixel_out.x <= cur_ray.x;
            pixel_out.y <= cur_ray.y;
            pixel_out.r <= color_t'(cur_ray.dir_x >> FRAC_BITS);
            pixel_out.g <= color_t'(cur_ray.dir_y >> FRAC_BITS);
            pixel_out.b <= color_t'(cur_ray.dir_z >> FRAC_BITS);
        end
    end

endmodule

`default_nettype wire

//--- hw/ray_core_pkg.sv
// Ray core shared types
`default_nettype none

package ray_core_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int COORD_W   = 12;
    localparam int FIXED_W   = 16;
    localparam int FRAC_BITS = 8;
    localparam int COLOR_W   = 8;

    typedef logic [COORD_W-1:0] coord_t;

    // unsigned 8.8 fixed point
    typedef logic [FIXED_W-1:0] fixed_t;

    typedef logic [COLOR_W-1:0] color_t;

    // ------------------------------------------------------------------------
    // pixel items
    // ------------------------------------------------------------------------
    // raw item from the ray generator side, 72 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        fixed_t dir_x;
        fixed_t dir_y;
        fixed_t dir_z;
    } ray_pixel_t;

    // colored item after raster, 48 bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        color_t r;
        color_t g;
        color_t b;
    } color_pixel_t;

    // stage machines
    typedef enum logic [1:0] {RAS_IDLE, RAS_RASTER, RAS_DONE} raster_state_t;
    typedef enum logic {PASS_IDLE, PASS_DONE} pass_state_t;

endpackage

`default_nettype wire

//--- hw/ray_core_top.sv
// Three-stage pixel pipeline
`timescale 1ns/100ps
`default_nettype none

module ray_core_top #(
    parameter int RASTER_CYCLES = 16
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       in_valid,
    input  ray_core_pkg::ray_pixel_t   in_pixel,
    input  logic                       out_full,
    output logic                       in_full,
    output logic                       out_valid,
    output ray_core_pkg::color_pixel_t out_pixel
);
    import ray_core_pkg::*;

    logic ras_take, ras_start, ras_finish, ras_emit;
    logic shdw_take, shdw_emit, shdr_take, shdr_emit;
    logic shdw_slot_full, shdr_slot_full;
    logic shdw_cur_full, shdr_cur_full;

    ray_pixel_t   ras_ray;
    color_pixel_t ras_pixel;
    color_pixel_t shdw_in_pixel, shdw_cur_pixel;
    color_pixel_t shdr_in_pixel;

    // ------------------------------------------------------------------------
    // raster stage
    // ------------------------------------------------------------------------
    stage_slot #(.payload_t(ray_pixel_t)) u_ras_slot (
        .clk(clk), .resetn(resetn),
        .load(in_valid), .data_in(in_pixel), .take(ras_take),
        .full(in_full), .data_out(ras_ray)
    );

    ray_color_convert u_convert (
        .clk(clk), .resetn(resetn),
        .start(ras_start), .finish(ras_finish),
        .ray_in(ras_ray), .pixel_out(ras_pixel)
    );

    // ------------------------------------------------------------------------
    // shadowing and shader stages
    // ------------------------------------------------------------------------
    stage_slot #(.payload_t(color_pixel_t)) u_shdw_in_slot (
        .clk(clk), .resetn(resetn),
        .load(ras_emit), .data_in(ras_pixel), .take(shdw_take),
        .full(shdw_slot_full), .data_out(shdw_in_pixel)
    );

    stage_slot #(.payload_t(color_pixel_t)) u_shdw_cur_slot (
        .clk(clk), .resetn(resetn),
        .load(shdw_take), .data_in(shdw_in_pixel), .take(shdw_emit),
        .full(shdw_cur_full), .data_out(shdw_cur_pixel)
    );

    stage_slot #(.payload_t(color_pixel_t)) u_shdr_in_slot (
        .clk(clk), .resetn(resetn),
        .load(shdw_emit), .data_in(shdw_cur_pixel), .take(shdr_take),
        .full(shdr_slot_full), .data_out(shdr_in_pixel)
    );

    stage_slot #(.payload_t(color_pixel_t)) u_shdr_cur_slot (
        .clk(clk), .resetn(resetn),
        .load(shdr_take), .data_in(shdr_in_pixel), .take(shdr_emit),
        .full(shdr_cur_full), .data_out(out_pixel)
    );

    ray_stage_ctrl #(.RASTER_CYCLES(RASTER_CYCLES)) u_ctrl (
        .clk(clk), .resetn(resetn),
        .in_slot_full(in_full), .shdw_slot_full(shdw_slot_full),
        .shdr_slot_full(shdr_slot_full), .out_full(out_full),
        .ras_take(ras_take), .ras_start(ras_start),
        .ras_finish(ras_finish), .ras_emit(ras_emit),
        .shdw_take(shdw_take), .shdw_emit(shdw_emit),
        .shdr_take(shdr_take), .shdr_emit(shdr_emit)
    );

    assign out_valid = shdr_emit;

    // a stage only starts once its previous pixel has left
    assert property (@(posedge clk) disable iff (!resetn) shdw_take |-> !shdw_cur_full)
        else $error("shadowing pixel overwritten");
    assert property (@(posedge clk) disable iff (!resetn) shdr_take |-> !shdr_cur_full)
        else $error("shader pixel overwritten");

endmodule

`default_nettype wire

//--- hw/ray_stage_ctrl.sv
// Pixel pipeline stage control
`timescale 1ns/100ps
`default_nettype none

module ray_stage_ctrl #(
    parameter int RASTER_CYCLES = 16
) (
    input  logic clk,
    input  logic resetn,
    input  logic in_slot_full,
    input  logic shdw_slot_full,
    input  logic shdr_slot_full,
    input  logic out_full,
    output logic ras_take,
    output logic ras_start,
    output logic ras_finish,
    output logic ras_emit,
    output logic shdw_take,
    output logic shdw_emit,
    output logic shdr_take,
    output logic shdr_emit
);
    import ray_core_pkg::*;

    localparam int CNT_W = $clog2(RASTER_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RASTER_CYCLES - 1);

    // ------------------------------------------------------------------------
    // raster stage
    // ------------------------------------------------------------------------
    raster_state_t    ras_state;
    logic [CNT_W-1:0] ras_count;

    assign ras_take   = (ras_state == RAS_IDLE) && in_slot_full;
    assign ras_start  = ras_take;
    assign ras_finish = (ras_state == RAS_RASTER) && (ras_count == CNT_LAST);
    assign ras_emit   = (ras_state == RAS_DONE) && !shdw_slot_full;

    // stands in for traversal, RASTER_CYCLES cycles per pixel
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ras_state <= RAS_IDLE;
            ras_count <= '0;
        end else begin
            case (ras_state)
                RAS_IDLE: begin
                    if (ras_start) begin
                        ras_state <= RAS_RASTER;
                    end
                end
                RAS_RASTER: begin
                    if (ras_finish) begin
                        ras_count <= '0;
                        ras_state <= RAS_DONE;
                    end else begin
                        ras_count <= ras_count + 1'b1;
                    end
                end
                RAS_DONE: begin
                    if (ras_emit) begin
                        ras_state <= RAS_IDLE;
                    end
                end
                default: begin
                    ras_state <= RAS_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // shadowing and shader stages
    // ------------------------------------------------------------------------
    // index 0 is shadowing, index 1 is shader
    logic [1:0]  pass_slot_full;
    logic [1:0]  pass_down_full;
    logic [1:0]  pass_take;
    logic [1:0]  pass_emit;
    pass_state_t pass_state [2];

    assign pass_slot_full = {shdr_slot_full, shdw_slot_full};
    assign pass_down_full = {out_full, shdr_slot_full};

    for (genvar i = 0; i < 2; i++) begin : g_pass
        assign pass_take[i] = (pass_state[i] == PASS_IDLE) && pass_slot_full[i];
        assign pass_emit[i] = (pass_state[i] == PASS_DONE) && !pass_down_full[i];

        always_ff @(posedge clk or negedge resetn) begin
            if (!resetn) begin
                pass_state[i] <= PASS_IDLE;
            end else if (pass_take[i]) begin
                pass_state[i] <= PASS_DONE;
            end else if (pass_emit[i]) begin
                pass_state[i] <= PASS_IDLE;
            end
        end
    end

    assign shdw_take = pass_take[0];
    assign shdw_emit = pass_emit[0];
    assign shdr_take = pass_take[1];
    assign shdr_emit = pass_emit[1];

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // an emitted pixel lands in an empty slot and is held there next cycle
    property emit_lands(logic emit, logic next_full);
        @(posedge clk) disable iff (!resetn) emit |-> !next_full ##1 next_full;
    endproperty

    property single_pulse(logic emit);
        @(posedge clk) disable iff (!resetn) emit |=> !emit;
    endproperty

    assert property (emit_lands(ras_emit, shdw_slot_full))
        else $error("raster emit into a busy shadowing slot");
    assert property (emit_lands(shdw_emit, shdr_slot_full))
        else $error("shadowing emit into a busy shader slot");

    assert property (single_pulse(ras_emit)) else $error("raster emit held");
    assert property (single_pulse(shdw_emit)) else $error("shadowing emit held");
    assert property (single_pulse(shdr_emit)) else $error("shader emit held");

endmodule

`default_nettype wire

//--- hw/stage_slot.sv
// One-entry stage buffer
`timescale 1ns/100ps
`default_nettype none

module stage_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     load,
    input  payload_t data_in,
    input  logic     take,
    output logic     full,
    output payload_t data_out
);

    // accept only into an empty slot
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b0;
        end else if (load && !full) begin
            full <= 1'b1;
        end
    end

    // payload holds until the next accepted load
    always_ff @(posedge clk) begin
        if (load && !full) begin
            data_out <= data_in;
        end
    end

    // a take must always find an item
    assert property (@(posedge clk) disable iff (!resetn) take |-> full)
        else $error("stage_slot: take while empty");

endmodule

`default_nettype wire

//--- sim/ray_core_tb.sv
// Pixel pipeline testbench
`timescale 1ns/100ps
`default_nettype none

module ray_core_tb #(
    parameter int RASTER_CYCLES = 16
);
    import ray_core_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 5;
    localparam int TOTAL_PIXELS    = 78;
    localparam int STALL_CYCLES    = 160 + 6 * 35;
    localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * (RASTER_CYCLES + 12) + STALL_CYCLES;

    logic         clk;
    logic         resetn;
    logic         in_valid;
    ray_pixel_t   in_pixel;
    logic         out_full;
    logic         in_full;
    logic         out_valid;
    color_pixel_t out_pixel;

    color_pixel_t expect_q[$];
    color_pixel_t ghost_pixel;
    color_pixel_t last_out;
    logic         ghost_armed = 1'b0;
    logic [31:0]  lfsr_state = 32'hfae1d983;
    string        cur_test = "reset";
    int           errors = 0;
    int           err_start = 0;
    int           tests_run = 0;
    int           accept_count = 0;
    int           out_count = 0;
    int           acc_mark;
    int           out_mark;
    int           stall_gap [6];
    int           stall_hold[6];

    ray_core_top #(.RASTER_CYCLES(RASTER_CYCLES)) dut (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_pixel(in_pixel), .out_full(out_full),
        .in_full(in_full), .out_valid(out_valid), .out_pixel(out_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic ray_pixel_t random_pixel();
        ray_pixel_t p;
        p.x     = coord_t'(rand_bits(12));
        p.y     = coord_t'(rand_bits(12));
        p.dir_x = fixed_t'(rand_bits(16));
        p.dir_y = fixed_t'(rand_bits(16));
        p.dir_z = fixed_t'(rand_bits(16));
        return p;
    endfunction

    // whole part of each direction component becomes its channel
    function automatic color_pixel_t expected_color(input ray_pixel_t p);
        color_pixel_t c;
        c.x = p.x;
        c.y = p.y;
        c.r = p.dir_x[FRAC_BITS +: COLOR_W];
        c.g = p.dir_y[FRAC_BITS +: COLOR_W];
        c.b = p.dir_z[FRAC_BITS +: COLOR_W];
        return c;
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic offer_pixel(input ray_pixel_t p);
        while (in_full) begin
            step();
        end
        in_valid = 1'b1;
        in_pixel = p;
        step();
        in_valid = 1'b0;
    endtask

    // all expected pixels out, then a few quiet cycles to catch duplicates
    task automatic drain();
        while (expect_q.size() != 0) begin
            step();
        end
        repeat (4) step();
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_start = errors;
        acc_mark = accept_count;
        out_mark = out_count;
    endtask

    task automatic end_test(input int n_in);
        if (accept_count - acc_mark != n_in || out_count - out_mark != n_in) begin
            $display("%s: %0d pixels accepted and %0d out, %0d wanted", cur_test,
                     accept_count - acc_mark, out_count - out_mark, n_in);
            errors++;
        end
        tests_run++;
        if (errors == err_start) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, errors - err_start);
        end
    endtask

    task automatic check_idle();
        if (in_full !== 1'b0 || out_valid !== 1'b0) begin
            $display("%s: in_full or out_valid is not low under reset", cur_test);
            errors++;
        end
    endtask

    // long stall to back up the whole pipe, then short random ones
    task automatic stall_output();
        out_full = 1'b1;
        repeat (160) step();
        if (!in_full) begin
            $display("%s: in_full still low after a long output stall", cur_test);
            errors++;
        end
        out_full = 1'b0;
        for (int i = 0; i < 6; i++) begin
            repeat (stall_gap[i]) step();
            out_full = 1'b1;
            repeat (stall_hold[i]) step();
            out_full = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // monitors, sampled at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (resetn && in_valid && !in_full) begin
            expect_q.push_back(expected_color(in_pixel));
            accept_count++;
        end
    end

    always @(negedge clk) begin
        if (resetn && out_valid) begin
            out_count++;
            last_out = out_pixel;
            if (out_full) begin
                $display("%s: out_valid raised while out_full is high", cur_test);
                errors++;
            end
            if (ghost_armed && out_pixel === ghost_pixel) begin
                $display("%s: the pixel offered while in_full was high came out", cur_test);
                errors++;
            end
            if (expect_q.size() == 0) begin
                $display("%s: a pixel came out with none pending", cur_test);
                errors++;
            end else begin
                if (out_pixel !== expect_q[0]) begin
                    $display("[FAIL] %s: expected %h, actual %h", cur_test, expect_q[0],
                             out_pixel);
                    errors++;
                end
                void'(expect_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run took longer than %0d cycles", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        ray_pixel_t fixed_ray;
        ray_pixel_t ghost_ray;
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_pixel = '0;
        out_full = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        check_idle();
        resetn = 1'b1;
        step();

        begin_test("single_pixel");
        fixed_ray = {12'h123, 12'h456, 16'h1280, 16'hab01, 16'h00ff};
        offer_pixel(fixed_ray);
        drain();
        if (last_out !== 48'h12345612ab00) begin
            $display("[FAIL] %s: expected %h, actual %h", cur_test, 48'h12345612ab00,
                     last_out);
            errors++;
        end
        end_test(1);

        begin_test("stream");
        repeat (40) offer_pixel(random_pixel());
        drain();
        end_test(40);

        begin_test("back_pressure");
        // random output stall lengths
        for (int i = 0; i < 6; i++) begin
            stall_gap[i]  = int'(rand_bits(5)) + 1;
            stall_hold[i] = int'(rand_bits(5)) + 4;
        end
        fork
            repeat (24) offer_pixel(random_pixel());
            stall_output();
        join
        drain();
        end_test(24);

        begin_test("ignored_offer");
        ghost_ray   = {12'hfff, 12'h0ff, 16'hdead, 16'hbeef, 16'hc0de};
        ghost_pixel = expected_color(ghost_ray);
        ghost_armed = 1'b1;
        offer_pixel(random_pixel());
        if (!in_full) begin
            $display("%s: in_full low right after an accept, offer not blocked", cur_test);
            errors++;
        end
        in_valid = 1'b1;
        in_pixel = ghost_ray;
        step();
        in_valid = 1'b0;
        offer_pixel(random_pixel());
        offer_pixel(random_pixel());
        drain();
        end_test(3);

        begin_test("mid_stream_reset");
        repeat (8) offer_pixel(random_pixel());
        resetn = 1'b0;
        expect_q.delete();
        repeat (3) step();
        check_idle();
        resetn = 1'b1;
        acc_mark = accept_count;
        out_mark = out_count;
        repeat (RASTER_CYCLES + 12) step();
        offer_pixel(random_pixel());
        drain();
        end_test(1);

        $display("%0d tests, %0d pixels accepted, %0d out, %0d errors", tests_run,
                 accept_count, out_count, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
